// File: logic/div_cmd_pkg.sv
package div_cmd_pkg;

  // selects how operands are interpreted
  typedef enum logic {
    DIV_UNSIGNED = 1'b0,
    DIV_SIGNED   = 1'b1
  } div_sign_e;

  // sideband captured by decode and consumed by the result stage
  typedef struct packed {
    logic neg_quot;
    logic neg_rem;
    logic div_by_zero;
  } op_flags_t;

endpackage

// File: logic/div_decode.sv
`timescale 1ns/1ps
`include "div_defs.svh"

module div_decode (
  input  logic                   clk,
  input  logic                   rstn,
  input  logic                   en,
  input  div_cmd_pkg::div_sign_e op_signed,
  input  div_types_pkg::data_t   dividend,
  input  div_types_pkg::data_t   divisor,
  output logic                   ready,
  div_op_if.decode               op
);
  import div_types_pkg::*;
  import div_cmd_pkg::*;

  logic      accept;
  logic      pending;
  logic      dividend_neg;
  logic      divisor_neg;
  data_t     dividend_abs;
  data_t     divisor_abs;
  op_flags_t flags_next;

  // pending covers the gap between acceptance and execute raising busy
  assign ready  = !(pending || op.busy);
  assign accept = en && ready;

  // sign bits only matter in signed mode
  assign dividend_neg = (op_signed == DIV_SIGNED) && dividend[`DIV_WIDTH-1];
  assign divisor_neg  = (op_signed == DIV_SIGNED) && divisor[`DIV_WIDTH-1];

  assign dividend_abs = dividend_neg ? -dividend : dividend;
  assign divisor_abs  = divisor_neg ? -divisor : divisor;

  always_comb begin
    flags_next.neg_quot    = dividend_neg ^ divisor_neg;
    flags_next.neg_rem     = dividend_neg;
    flags_next.div_by_zero = (divisor == '0);
  end

  // start follows acceptance by one cycle, pending drops once start is seen
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      pending  <= 1'b0;
      op.start <= 1'b0;
    end else begin
      op.start <= 1'b0;
      if (accept) begin
        pending <= 1'b1;
      end
      if (pending && !op.start) begin
        op.start <= 1'b1;
      end
      if (op.start) begin
        pending <= 1'b0;
      end
    end
  end

  // operation fields stay put until the next accepted operation
  always_ff @(posedge clk) begin
    if (accept) begin
      op.dividend_mag  <= dividend_abs;
      op.divisor_mag   <= divisor_abs;
      op.flags         <= flags_next;
      op.orig_dividend <= dividend;
    end
  end

  // busy comes from execute, so this ties the two blocks together
  a_start_when_idle: assert property (
    @(posedge clk) disable iff (!rstn)
    $rose(op.start) |-> !op.busy
  ) else $error("start raised while execute is busy");

endmodule

// File: logic/div_defs.svh
`ifndef DIV_DEFS_SVH
`define DIV_DEFS_SVH

// operand width in bits, shared by every datapath in the divide unit
`define DIV_WIDTH 8

// one quotient bit is resolved per iteration of the restoring loop
`define DIV_ITER `DIV_WIDTH

`endif

// File: logic/div_execute.sv
`timescale 1ns/1ps
`include "div_defs.svh"

module div_execute (
  input logic        clk,
  input logic        rstn,
  div_op_if.execute  op,
  div_res_if.execute res
);
  import div_types_pkg::*;

  exec_state_e state;
  exec_state_e state_next;
  wide_t       work;
  wide_t       divisor_e;
  logic        work_carry;
  cnt_t        cnt;
  logic        drain;

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

  // each round shifts first, then tries the subtraction
  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (op.start) begin
          state_next = LOAD;
        end
      end
      LOAD: state_next = SHIFT;
      SHIFT: state_next = SUB;
      SUB: begin
        if (cnt == cnt_t'(`DIV_ITER)) begin
          state_next = DONE;
        end else begin
          state_next = SHIFT;
        end
      end
      DONE: state_next = IDLE;
      default: state_next = IDLE;
    endcase
  end

  // drain keeps busy up while the result stage presents its output
  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      cnt   <= '0;
      drain <= 1'b0;
    end else begin
      drain <= (state == DONE);
      if (state == LOAD) begin
        cnt <= '0;
      end else if (state == SHIFT) begin
        cnt <= cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    case (state)
      LOAD: begin
        work       <= wide_t'(op.dividend_mag);
        divisor_e  <= {op.divisor_mag, {`DIV_WIDTH{1'b0}}};
        work_carry <= 1'b0;
      end
      SHIFT: begin
        {work_carry, work} <= {work, 1'b0};
      end
      SUB: begin
        // the carry means the partial remainder already exceeds the divisor
        if (work_carry || (work >= divisor_e)) begin
          work <= work - divisor_e + 1'b1;
        end
        work_carry <= 1'b0;
      end
      default: begin
        work <= work;
      end
    endcase
  end

  assign op.busy      = (state != IDLE) || drain;
  assign res.done     = (state == DONE);
  assign res.raw_quot = work[`DIV_WIDTH-1:0];
  assign res.raw_rem  = work[2*`DIV_WIDTH-1:`DIV_WIDTH];

  a_done_pulse: assert property (
    @(posedge clk) disable iff (!rstn)
    res.done |=> !res.done
  ) else $error("done held for more than one cycle");

  a_iter_bound: assert property (
    @(posedge clk) disable iff (!rstn)
    cnt <= cnt_t'(`DIV_ITER)
  ) else $error("iteration count out of range");

endmodule

// File: logic/div_ifs.sv
`timescale 1ns/1ps

// operation handed from decode to execute and result
interface div_op_if;
  import div_types_pkg::*;
  import div_cmd_pkg::*;

  logic      start;
  data_t     dividend_mag;
  data_t     divisor_mag;
  op_flags_t flags;
  data_t     orig_dividend;
  logic      busy;

  modport decode (
    output start,
    output dividend_mag,
    output divisor_mag,
    output flags,
    output orig_dividend,
    input  busy
  );

  modport execute (
    input  start,
    input  dividend_mag,
    input  divisor_mag,
    output busy
  );

  // sign correction needs the flags and the untouched dividend
  modport result (
    input flags,
    input orig_dividend
  );

endinterface

// raw unsigned result from execute to result
interface div_res_if;
  import div_types_pkg::*;

  logic  done;
  data_t raw_quot;
  data_t raw_rem;

  modport execute (
    output done,
    output raw_quot,
    output raw_rem
  );

  modport result (
    input done,
    input raw_quot,
    input raw_rem
  );

endinterface

// File: logic/div_result.sv
`timescale 1ns/1ps

module div_result (
  input  logic                 clk,
  input  logic                 rstn,
  div_op_if.result             op,
  div_res_if.result            res,
  output div_types_pkg::data_t quotient,
  output div_types_pkg::data_t remainder,
  output logic                 div_by_zero,
  output logic                 vld_out
);
  import div_types_pkg::*;

  data_t quot_fixed;
  data_t rem_fixed;

  // magnitudes get their signs back here, the zero divisor overrides both
  always_comb begin
    quot_fixed = op.flags.neg_quot ? -res.raw_quot : res.raw_quot;
    rem_fixed  = op.flags.neg_rem ? -res.raw_rem : res.raw_rem;
    if (op.flags.div_by_zero) begin
      quot_fixed = '1;
      rem_fixed  = op.orig_dividend;
    end
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      vld_out <= 1'b0;
    end else begin
      vld_out <= res.done;
    end
  end

  // outputs hold until the next done overwrites them
  always_ff @(posedge clk) begin
    if (res.done) begin
      quotient    <= quot_fixed;
      remainder   <= rem_fixed;
      div_by_zero <= op.flags.div_by_zero;
    end
  end

  a_vld_pulse: assert property (
    @(posedge clk) disable iff (!rstn)
    vld_out |=> !vld_out
  ) else $error("vld_out is not a single cycle pulse after done");

endmodule

// File: logic/div_top.sv
`timescale 1ns/1ps

module div_top (
  input  logic                   clk,
  input  logic                   rstn,
  input  logic                   en,
  input  div_cmd_pkg::div_sign_e op_signed,
  input  div_types_pkg::data_t   dividend,
  input  div_types_pkg::data_t   divisor,
  output logic                   ready,
  output div_types_pkg::data_t   quotient,
  output div_types_pkg::data_t   remainder,
  output logic                   div_by_zero,
  output logic                   vld_out
);

  div_op_if  op_bus ();
  div_res_if res_bus ();

  // captures the operation and strips the signs
  div_decode u_decode (
    .clk       (clk),
    .rstn      (rstn),
    .en        (en),
    .op_signed (op_signed),
    .dividend  (dividend),
    .divisor   (divisor),
    .ready     (ready),
    .op        (op_bus.decode)
  );

  // unsigned restoring loop, one bit every two cycles
  div_execute u_execute (
    .clk  (clk),
    .rstn (rstn),
    .op   (op_bus.execute),
    .res  (res_bus.execute)
  );

  div_result u_result (
    .clk         (clk),
    .rstn        (rstn),
    .op          (op_bus.result),
    .res         (res_bus.result),
    .quotient    (quotient),
    .remainder   (remainder),
    .div_by_zero (div_by_zero),
    .vld_out     (vld_out)
  );

endmodule

// File: logic/div_types_pkg.sv
`include "div_defs.svh"

package div_types_pkg;

  // operands, quotient and remainder
  typedef logic [`DIV_WIDTH-1:0] data_t;

  // working register of the execute block, remainder in the upper half
  typedef logic [2*`DIV_WIDTH-1:0] wide_t;

  // iteration counter, must reach DIV_ITER itself
  typedef logic [$clog2(`DIV_ITER+1)-1:0] cnt_t;

  typedef enum logic [2:0] {
    IDLE,
    LOAD,
    SUB,
    SHIFT,
    DONE
  } exec_state_e;

endpackage

// File: verif/div_tb.sv
`timescale 1ns/1ps
`include "div_defs.svh"

module div_tb;
  import div_types_pkg::*;
  import div_cmd_pkg::*;

  localparam int LATENCY    = 2*`DIV_WIDTH+4;
  localparam int WAIT_LIMIT = 2*`DIV_WIDTH+8;
  localparam int N_RANDOM   = 200;
  localparam int unsigned SEED = 32'h346c_3210;

  logic      clk;
  logic      rstn;
  logic      en;
  div_sign_e op_signed;
  data_t     dividend;
  data_t     divisor;
  logic      ready;
  data_t     quotient;
  data_t     remainder;
  logic      div_by_zero;
  logic      vld_out;

  // expected result of the operation in flight, taken at acceptance
  data_t exp_quot;
  data_t exp_rem;
  logic  exp_dbz;

  int          outstanding;
  int          accepted;
  int          results;
  int          issued;
  int          value_errors;
  int          protocol_errors;
  int          timeouts;
  bit          aborted;

  div_top uut (
    .clk         (clk),
    .rstn        (rstn),
    .en          (en),
    .op_signed   (op_signed),
    .dividend    (dividend),
    .divisor     (divisor),
    .ready       (ready),
    .quotient    (quotient),
    .remainder   (remainder),
    .div_by_zero (div_by_zero),
    .vld_out     (vld_out)
  );

  always #2 clk = ~clk;

  // truncating division for signed mode, remainder follows the dividend
  task automatic model_div(input div_sign_e mode, input data_t a, input data_t b,
                           output data_t q, output data_t r, output logic z);
    int sa;
    int sb;
    z = (b == '0);
    if (z) begin
      q = '1;
      r = a;
    end else if (mode == DIV_SIGNED) begin
      sa = $signed(a);
      sb = $signed(b);
      q  = data_t'(sa / sb);
      r  = data_t'(sa % sb);
    end else begin
      q = a / b;
      r = a % b;
    end
  endtask

  always @(posedge clk) begin : track_ops
    data_t q;
    data_t r;
    logic  z;
    if (rstn && en && ready) begin
      model_div(op_signed, dividend, divisor, q, r, z);
      exp_quot <= q;
      exp_rem  <= r;
      exp_dbz  <= z;
      accepted <= accepted + 1;
    end
    if (rstn && vld_out) begin
      results <= results + 1;
    end
    outstanding <= outstanding + ((rstn && en && ready) ? 1 : 0) - (vld_out ? 1 : 0);
  end

  a_reset_ready: assert property (
    @(posedge clk) (!rstn || $rose(rstn)) |-> ready
  ) else begin
    protocol_errors++;
    $display("** Error at %0t: ready = %b, expected 1", $time, ready);
  end

  a_reset_vld: assert property (
    @(posedge clk) (!rstn || $rose(rstn)) |-> !vld_out
  ) else begin
    protocol_errors++;
    $display("** Error at %0t: vld_out = %b, expected 0", $time, vld_out);
  end

  // ready is low from the edge after acceptance up to and including the pulse
  a_busy_ready: assert property (
    @(posedge clk) disable iff (!rstn)
    (en && ready) |=> (!ready [*LATENCY+1]) ##1 ready
  ) else begin
    protocol_errors++;
    $display("at %0t ready did not stay low for the whole operation", $time);
  end

  a_latency: assert property (
    @(posedge clk) disable iff (!rstn)
    (en && ready) |=> (!vld_out [*LATENCY]) ##1 vld_out
  ) else begin
    protocol_errors++;
    $display("at %0t vld_out did not arrive %0d cycles after acceptance", $time, LATENCY);
  end

  a_vld_single: assert property (
    @(posedge clk) disable iff (!rstn)
    vld_out |=> !vld_out
  ) else begin
    protocol_errors++;
    $display("at %0t vld_out stayed high for more than one cycle", $time);
  end

  a_one_result: assert property (
    @(posedge clk) disable iff (!rstn)
    vld_out |-> (outstanding == 1)
  ) else begin
    protocol_errors++;
    $display("at %0t a result appeared with no accepted operation pending", $time);
  end

  a_quot: assert property (
    @(posedge clk) disable iff (!rstn)
    vld_out |-> (quotient == exp_quot)
  ) else begin
    value_errors++;
    $display("** Error at %0t: quotient = 0x%h, expected 0x%h", $time, quotient, exp_quot);
  end

  a_rem: assert property (
    @(posedge clk) disable iff (!rstn)
    vld_out |-> (remainder == exp_rem)
  ) else begin
    value_errors++;
    $display("** Error at %0t: remainder = 0x%h, expected 0x%h", $time, remainder, exp_rem);
  end

  a_dbz: assert property (
    @(posedge clk) disable iff (!rstn)
    vld_out |-> (div_by_zero == exp_dbz)
  ) else begin
    value_errors++;
    $display("** Error at %0t: div_by_zero = %b, expected %b", $time, div_by_zero, exp_dbz);
  end

  // junk on the inputs while the DUT is busy must not reach the result
  task automatic scramble_inputs();
    op_signed = div_sign_e'($urandom_range(0, 1));
    dividend  = data_t'($urandom);
    divisor   = data_t'($urandom);
  endtask

  // called and returns half a nanosecond after a rising edge
  task automatic run_div(input div_sign_e mode, input data_t a, input data_t b, input bit hold);
    int waited;
    if (aborted) begin
      return;
    end
    waited = 0;
    while (!ready && waited < WAIT_LIMIT) begin
      @(posedge clk);
      #0.5;
      waited++;
    end
    if (!ready) begin
      timeouts++;
      aborted = 1'b1;
      $display("timeout at %0t: ready never returned high", $time);
      return;
    end
    en        = 1'b1;
    op_signed = mode;
    dividend  = a;
    divisor   = b;
    issued++;
    @(posedge clk);
    #0.5;
    if (hold) begin
      scramble_inputs();
    end else begin
      en = 1'b0;
    end
    waited = 0;
    while (!vld_out && waited < WAIT_LIMIT) begin
      @(posedge clk);
      #0.5;
      waited++;
      if (hold) begin
        scramble_inputs();
      end
    end
    en = 1'b0;
    if (!vld_out) begin
      timeouts++;
      aborted = 1'b1;
      $display("timeout at %0t: no vld_out after an accepted operation", $time);
    end
  endtask

  task automatic random_unsigned();
    for (int i = 0; i < N_RANDOM; i++) begin
      run_div(DIV_UNSIGNED, data_t'($urandom), data_t'($urandom), 1'b0);
    end
    run_div(DIV_UNSIGNED, 8'hff, 8'h01, 1'b0);
    run_div(DIV_UNSIGNED, 8'h00, 8'h05, 1'b0);
    run_div(DIV_UNSIGNED, 8'h05, 8'hff, 1'b0);
    run_div(DIV_UNSIGNED, 8'hff, 8'hff, 1'b0);
  endtask

  // every sign combination plus the overflow case
  task automatic signed_corners();
    run_div(DIV_SIGNED, data_t'(100), data_t'(7), 1'b0);
    run_div(DIV_SIGNED, data_t'(-100), data_t'(7), 1'b0);
    run_div(DIV_SIGNED, data_t'(100), data_t'(-7), 1'b0);
    run_div(DIV_SIGNED, data_t'(-100), data_t'(-7), 1'b0);
    run_div(DIV_SIGNED, 8'h80, 8'hff, 1'b0);
    run_div(DIV_SIGNED, 8'h80, 8'h01, 1'b0);
    run_div(DIV_SIGNED, 8'h7f, 8'h80, 1'b0);
    run_div(DIV_SIGNED, 8'hff, 8'h7f, 1'b0);
  endtask

  task automatic random_signed();
    for (int i = 0; i < N_RANDOM; i++) begin
      run_div(DIV_SIGNED, data_t'($urandom), data_t'($urandom), 1'b0);
    end
  endtask

  task automatic zero_divisors();
    run_div(DIV_UNSIGNED, 8'hc8, 8'h00, 1'b0);
    run_div(DIV_UNSIGNED, 8'h00, 8'h00, 1'b0);
    run_div(DIV_SIGNED, data_t'(-50), 8'h00, 1'b0);
    run_div(DIV_SIGNED, data_t'(77), 8'h00, 1'b0);
  endtask

  task automatic en_held_while_busy();
    run_div(DIV_UNSIGNED, 8'hc3, 8'h0b, 1'b1);
    run_div(DIV_SIGNED, data_t'(-77), data_t'(9), 1'b1);
    for (int i = 0; i < 10; i++) begin
      run_div(div_sign_e'(i % 2), data_t'($urandom), data_t'($urandom), 1'b1);
    end
  endtask

  initial begin
    void'($urandom(SEED));
    clk             = 1'b0;
    rstn            = 1'b0;
    en              = 1'b0;
    op_signed       = DIV_UNSIGNED;
    dividend        = '0;
    divisor         = '0;
    outstanding     = 0;
    accepted        = 0;
    results         = 0;
    issued          = 0;
    value_errors    = 0;
    protocol_errors = 0;
    timeouts        = 0;
    aborted         = 1'b0;
    repeat (2) @(posedge clk);
    #0.5;
    rstn = 1'b1;
    @(posedge clk);
    #0.5;

    random_unsigned();
    signed_corners();
    random_signed();
    zero_divisors();
    en_held_while_busy();

    // let the checks on the last result settle
    repeat (4) @(posedge clk);
    if (accepted != issued || results != issued) begin
      protocol_errors++;
      $display("issued %0d operations, DUT accepted %0d and returned %0d results",
               issued, accepted, results);
    end
    $display("errors: %0d value, %0d protocol, %0d timeout",
             value_errors, protocol_errors, timeouts);
    if (value_errors + protocol_errors + timeouts == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// File: verilog.f
+incdir+logic
logic/div_types_pkg.sv
logic/div_cmd_pkg.sv
logic/div_ifs.sv
logic/div_decode.sv
logic/div_execute.sv
logic/div_result.sv
logic/div_top.sv
verif/div_tb.sv
